/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only -Wall
TOP        = gfx_rom_map_tb
RTL_TOP    = gfx_rom_map
FILELIST   = gfx_rom_map.f
OBJ_DIR    = obj_dir
LOG        = sim.log

SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
RTL_FILES = $(shell grep -v -e '^+' -e '^test/' $(FILELIST))

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST) common/mapper_table.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "test passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+common --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/gfx_map_pkg.sv */
////////////////////
// Request-side types for the tile ROM bank mapper
// Layer encoding follows board address bits A[22:20]
// Tile code carries bits 15:6 only, the lower bits never reach the mapper
////////////////////
`default_nettype none

package gfx_map_pkg;

    localparam int CODE_W = 10;   // Tile code bits 15:6
    localparam int ROW_W  = 7;    // Row inside the tile
    localparam int NBANKS = 4;    // ROM banks on the board

    // Graphics layer of a fetch
    typedef enum logic [2:0] {
        LAYER_OBJ   = 3'd0,
        LAYER_SCR1  = 3'd1,
        LAYER_SCR2  = 3'd2,
        LAYER_SCR3  = 3'd3,
        LAYER_STARS = 3'd4  // Star field
    } gfx_layer_e;

    // Board type, picks the bank table
    typedef enum logic [1:0] {
        GAME_NONE      = 2'd0,  // Nothing banked
        GAME_TWO_BANK  = 2'd1,
        GAME_FOUR_BANK = 2'd2
    } gfx_game_e;

    // One tile fetch, 20 bits
    typedef struct packed {
        gfx_layer_e        layer;
        logic [CODE_W-1:0] code;
        logic [ROW_W-1:0]  row;
    } tile_req_t;

    // Board configuration words, nibble n for bank n
    typedef struct packed {
        logic [4*NBANKS-1:0] bank_offset;
        logic [4*NBANKS-1:0] bank_mask;   // 1 keeps the code bit
    } bank_cfg_t;

endpackage

`default_nettype wire

/* common/gfx_rom_pkg.sv */
////////////////////
// ROM-side types, word address of 17 bits
// Address is hi nibble, then low code bits, then row
////////////////////
`default_nettype none

package gfx_rom_pkg;

    localparam int ROM_HI_W   = 4;   // Banked nibble
    localparam int ROM_LO_W   = 6;   // Code bits 11:6
    localparam int ROM_ROW_W  = 7;
    localparam int ROM_ADDR_W = ROM_HI_W + ROM_LO_W + ROM_ROW_W;  // 17

    // Mapper result handed to the address stage
    typedef struct packed {
        logic [ROM_HI_W-1:0]  offset;
        logic [ROM_HI_W-1:0]  mask;
        logic                 unmapped;  // No bank hit
        logic [ROM_HI_W-1:0]  hi;        // Code bits 15:12 as fetched
        logic [ROM_LO_W-1:0]  code_lo;
        logic [ROM_ROW_W-1:0] row;
    } mapped_tile_t;

    // Request sent on to the ROM
    typedef struct packed {
        logic [ROM_ADDR_W-1:0] addr;
        logic                  unmapped;
    } rom_req_t;

endpackage

`default_nettype wire

/* common/mapper_table.svh */
////////////////////
// Bank table, case items of a case on game
// Expects in_req, req_top2 and dec_sel in the including scope
// dec_sel is one-hot, all zero means no bank
////////////////////
`ifndef MAPPER_TABLE_SVH
`define MAPPER_TABLE_SVH

GAME_NONE: begin
    dec_sel = 4'b0000;  // Nothing banked
end

GAME_TWO_BANK: begin
    case (in_req.layer)
        LAYER_OBJ, LAYER_SCR1, LAYER_SCR2: begin
            // Split at code 0x200
            dec_sel = (in_req.code < 10'h200) ? 4'b0001 : 4'b0010;
        end
        LAYER_SCR3, LAYER_STARS: begin
            dec_sel = 4'b0010;
        end
        default: begin
            dec_sel = 4'b0000;  // Unused layer code
        end
    endcase
end

GAME_FOUR_BANK: begin
    case (in_req.layer)
        LAYER_OBJ: begin
            // Objects follow code bits 15:14
            case (req_top2)
                2'd0:    dec_sel = 4'b0001;
                2'd1:    dec_sel = 4'b0010;
                2'd2:    dec_sel = 4'b0100;
                default: dec_sel = 4'b0000;  // Top quarter not fitted
            endcase
        end
        LAYER_SCR1, LAYER_SCR2: begin
            dec_sel = 4'b0100;
        end
        LAYER_SCR3, LAYER_STARS: begin
            dec_sel = 4'b1000;
        end
        default: begin
            dec_sel = 4'b0000;
        end
    endcase
end

`endif

/* gfx_rom_map.f */
+incdir+common
common/gfx_map_pkg.sv
common/gfx_rom_pkg.sv
mapper/gfx_bank_mapper.sv
source/gfx_rom_addr.sv
source/gfx_rom_map.sv
test/gfx_rom_map_asserts.sv
test/gfx_rom_map_tb.sv

/* mapper/gfx_bank_mapper.sv */
////////////////////
// Two-stage bank mapper, decode then select
// game is sampled in decode, cfg in select
// Both must only change with the pipeline empty
////////////////////
`timescale 1ns/1ps
`default_nettype none

module gfx_bank_mapper (
    input  wire                      clk,
    input  wire                      rst,
    input  wire gfx_map_pkg::gfx_game_e game,
    input  wire gfx_map_pkg::bank_cfg_t cfg,
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire gfx_map_pkg::tile_req_t in_req,
    output logic                     m_valid,
    input  wire                      m_ready,
    output gfx_rom_pkg::mapped_tile_t m_tile
);
    import gfx_map_pkg::*;
    import gfx_rom_pkg::*;

    logic [NBANKS-1:0]   dec_sel;   // One-hot bank from the table
    logic [1:0]          req_top2;  // Code bits 15:14
    logic                s1_valid;
    logic                s1_ready;
    logic [CODE_W-1:0]   s1_code;
    logic [ROW_W-1:0]    s1_row;
    logic [NBANKS-1:0]   s1_sel;
    logic                s2_ready;
    logic [1:0]          sel_idx;
    logic                sel_hit;
    logic [ROM_HI_W-1:0] sel_offset;
    logic [ROM_HI_W-1:0] sel_mask;

    assign req_top2 = in_req.code[CODE_W-1 -: 2];

    // Decode
    always_comb begin
        dec_sel = '0;
        case (game)
            `include "mapper_table.svh"
            default: dec_sel = '0;  // Unknown board
        endcase
    end

    // Stage ready when empty or draining this edge
    assign s2_ready = !m_valid || m_ready;
    assign s1_ready = !s1_valid || s2_ready;
    assign in_ready = s1_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (s1_ready) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && s1_ready) begin
            s1_code <= in_req.code;
            s1_row  <= in_req.row;
            s1_sel  <= dec_sel;
        end
    end

    // Select, one-hot to nibble index
    always_comb begin
        sel_hit = 1'b1;
        case (s1_sel)
            4'b0001: sel_idx = 2'd0;
            4'b0010: sel_idx = 2'd1;
            4'b0100: sel_idx = 2'd2;
            4'b1000: sel_idx = 2'd3;
            default: begin
                sel_idx = 2'd0;
                sel_hit = 1'b0;  // No bank
            end
        endcase
    end

    // Unmapped fetch passes the code nibble through
    assign sel_offset = sel_hit ? cfg.bank_offset[sel_idx*ROM_HI_W +: ROM_HI_W] : 4'h0;
    assign sel_mask   = sel_hit ? cfg.bank_mask[sel_idx*ROM_HI_W +: ROM_HI_W] : 4'hF;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (s2_ready) begin
            m_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid && s2_ready) begin
            m_tile.offset   <= sel_offset;
            m_tile.mask     <= sel_mask;
            m_tile.unmapped <= !sel_hit;
            m_tile.hi       <= s1_code[CODE_W-1 -: ROM_HI_W];
            m_tile.code_lo  <= s1_code[ROM_LO_W-1:0];
            m_tile.row      <= s1_row;
        end
    end

endmodule

`default_nettype wire

/* source/gfx_rom_addr.sv */
////////////////////
// Address stage, one register deep
// out_req holds while out_valid is high and out_ready low
////////////////////
`timescale 1ns/1ps
`default_nettype none

module gfx_rom_addr (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       m_valid,
    output logic                      m_ready,
    input  wire gfx_rom_pkg::mapped_tile_t m_tile,
    output logic                      out_valid,
    input  wire                       out_ready,
    output gfx_rom_pkg::rom_req_t     out_req
);
    import gfx_rom_pkg::*;

    logic [ROM_HI_W-1:0]   merged_hi;
    logic [ROM_ADDR_W-1:0] addr;

    // Mask 1 keeps the code bit, 0 takes the bank offset
    assign merged_hi = (m_tile.hi & m_tile.mask) | (m_tile.offset & ~m_tile.mask);
    assign addr      = {merged_hi, m_tile.code_lo, m_tile.row};

    assign m_ready = !out_valid || out_ready;  // Empty or draining

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (m_ready) begin
            out_valid <= m_valid;
        end
    end

    // Loaded only on a transfer, so held under back-pressure
    always_ff @(posedge clk) begin
        if (m_valid && m_ready) begin
            out_req.addr     <= addr;
            out_req.unmapped <= m_tile.unmapped;
        end
    end

endmodule

`default_nettype wire

/* source/gfx_rom_map.sv */
////////////////////
// Graphics ROM address path, three stages
// out_valid rises after the third edge counting the accepting one
// At most three requests in flight
// game and cfg change only with nothing in flight
////////////////////
`timescale 1ns/1ps
`default_nettype none

module gfx_rom_map (
    input  wire                         clk,
    input  wire                         rst,
    input  wire gfx_map_pkg::gfx_game_e game,
    input  wire gfx_map_pkg::bank_cfg_t cfg,
    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire gfx_map_pkg::tile_req_t in_req,
    output logic                        out_valid,
    input  wire                         out_ready,
    output gfx_rom_pkg::rom_req_t       out_req
);
    import gfx_rom_pkg::*;

    logic         m_valid;  // Mapper to address stage
    logic         m_ready;
    mapped_tile_t m_tile;

    gfx_bank_mapper u_mapper (
        .clk      (clk),
        .rst      (rst),
        .game     (game),
        .cfg      (cfg),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_req   (in_req),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .m_tile   (m_tile)
    );

    gfx_rom_addr u_addr (
        .clk       (clk),
        .rst       (rst),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_tile    (m_tile),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_req   (out_req)
    );

endmodule

`default_nettype wire

/* test/gfx_rom_map_asserts.sv */
////////////////////
// Handshake checks bound into gfx_rom_map
// In-flight limit of three matches the three pipeline stages
////////////////////
`timescale 1ns/1ps
`default_nettype none

module gfx_rom_map_asserts (
    input wire                        clk,
    input wire                        rst,
    input wire                        in_valid,
    input wire                        in_ready,
    input wire                        out_valid,
    input wire                        out_ready,
    input wire gfx_rom_pkg::rom_req_t out_req
);
    logic [15:0] acc_cnt;  // Requests taken in
    logic [15:0] del_cnt;  // Results handed out

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_cnt <= '0;
            del_cnt <= '0;
        end else begin
            if (in_valid && in_ready) acc_cnt <= acc_cnt + 16'd1;
            if (out_valid && out_ready) del_cnt <= del_cnt + 16'd1;
        end
    end

    // Output stays quiet in reset
    a_rst_quiet: assert property (@(posedge clk) rst |-> !out_valid)
        else $error("out_valid high while in reset");

    // Stalled result must not move
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_req)))
        else $error("out_req or out_valid changed under back-pressure");

    a_in_flight: assert property (@(posedge clk) disable iff (rst)
        (acc_cnt - del_cnt) <= 16'd3)
        else $error("more than three requests in flight");

endmodule

bind gfx_rom_map gfx_rom_map_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_req   (out_req)
);

`default_nettype wire

/* test/gfx_rom_map_tb.sv */
////////////////////
// Testbench for gfx_rom_map, six tests in sequence
// game and cfg only change with the pipeline drained
// Results compared at the falling edge before each output transfer
////////////////////
`timescale 1ns/1ps
`default_nettype none

module gfx_rom_map_tb;
    import gfx_map_pkg::*;
    import gfx_rom_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int OUT_AFTER      = 2;  // Third register edge, counting the accepting one
    localparam int DRAIN_CYCLES   = 20;  // Three in flight need far fewer

    logic      clk;
    logic      rst;
    gfx_game_e game;
    bank_cfg_t cfg;
    logic      in_valid;
    logic      in_ready;
    tile_req_t in_req;
    logic      out_valid;
    logic      out_ready;
    rom_req_t  out_req;

    logic [15:0] lfsr = 16'd36906;  // Seed
    rom_req_t    exp_q[$];          // Expected results in order
    rom_req_t    mon_exp;
    int cycles          = 0;
    int errors          = 0;
    int err_start       = 0;
    int out_count       = 0;
    int tests_ok        = 0;
    int tests_bad       = 0;
    int timing_idx      = -1;  // Output index whose cycle is logged
    int first_acc_cycle = 0;
    int first_out_cycle = 0;
    int sent_total      = 0;
    logic stall_seen    = 1'b0;

    gfx_rom_map dut (
        .clk       (clk),
        .rst       (rst),
        .game      (game),
        .cfg       (cfg),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_req   (out_req)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);  // One step per bit
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // Expected ROM request, straight from the bank table rules
    function automatic rom_req_t expected_req(input gfx_game_e g, input bank_cfg_t c,
                                              input tile_req_t r);
        int         bank;
        logic [3:0] hi;
        logic [3:0] off;
        logic [3:0] msk;
        logic [3:0] nib;
        rom_req_t   res;
        hi   = r.code[9:6];
        bank = -1;  // No bank
        if (g == GAME_TWO_BANK) begin
            if (r.layer inside {LAYER_OBJ, LAYER_SCR1, LAYER_SCR2})
                bank = (r.code < 10'h200) ? 0 : 1;
            else if (r.layer inside {LAYER_SCR3, LAYER_STARS})
                bank = 1;
        end else if (g == GAME_FOUR_BANK) begin
            if (r.layer == LAYER_OBJ)
                bank = (hi[3:2] == 2'd3) ? -1 : int'(hi[3:2]);
            else if (r.layer inside {LAYER_SCR1, LAYER_SCR2})
                bank = 2;
            else if (r.layer inside {LAYER_SCR3, LAYER_STARS})
                bank = 3;
        end
        if (bank < 0) begin
            off = 4'h0;
            msk = 4'hF;
        end else begin
            off = c.bank_offset[4*bank +: 4];
            msk = c.bank_mask[4*bank +: 4];
        end
        for (int i = 0; i < 4; i++)
            nib[i] = msk[i] ? hi[i] : off[i];  // Mask 1 keeps the code bit
        res.addr     = {nib, r.code[5:0], r.row};
        res.unmapped = (bank < 0);
        return res;
    endfunction

    // Sends n random requests, optional random out_ready and forced top-quarter objects
    task automatic run_reqs(input int n, input logic bp, input logic force_top);
        int          sent;
        int          lay;
        logic        have_req;
        logic [15:0] r;
        sent     = 0;
        have_req = 1'b0;
        while (sent < n) begin
            @(posedge clk);
            #2;
            r = rand_bits(1);
            out_ready = bp ? r[0] : 1'b1;
            if (!have_req) begin
                r   = rand_bits(3);
                lay = int'(r) % 5;
                in_req.layer = gfx_layer_e'(lay[2:0]);
                r = rand_bits(10);
                in_req.code = r[9:0];
                r = rand_bits(7);
                in_req.row = r[6:0];
                if (force_top && (sent % 5 == 4)) begin
                    in_req.layer     = LAYER_OBJ;  // Bank-less quarter
                    in_req.code[9:8] = 2'b11;
                end
                in_valid = 1'b1;
                have_req = 1'b1;
            end
            @(negedge clk);
            if (in_ready) begin
                exp_q.push_back(expected_req(game, cfg, in_req));
                if (sent == 0) first_acc_cycle = cycles + 1;  // Accepting edge
                sent++;
                have_req = 1'b0;
            end else begin
                stall_seen = 1'b1;
            end
        end
        sent_total += sent;
        @(posedge clk);
        #2;
        in_valid  = 1'b0;
        out_ready = 1'b1;
    endtask

    // Waits for every pending result, bounded
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out", exp_q.size());
            errors++;
            exp_q.delete();
        end
        #2;
    endtask

    task automatic set_config(input gfx_game_e g, input logic [15:0] off,
                              input logic [15:0] msk);
        game            = g;
        cfg.bank_offset = off;
        cfg.bank_mask   = msk;
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == err_start) begin
            tests_ok++;
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("Test %0d %s: %0d errors", num, name, errors - err_start);
        end
        err_start = errors;
    endtask

    // Scoreboard, out_valid and out_ready are stable here
    always @(negedge clk) begin
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output at %0t with no request pending", $time);
                errors++;
            end else begin
                mon_exp = exp_q.pop_front();
                if (out_req.addr !== mon_exp.addr) begin
                    $display("FAIL %0t out_req.addr expected %h got %h",
                             $time, mon_exp.addr, out_req.addr);
                    errors++;
                end
                if (out_req.unmapped !== mon_exp.unmapped) begin
                    $display("FAIL %0t out_req.unmapped expected %b got %b",
                             $time, mon_exp.unmapped, out_req.unmapped);
                    errors++;
                end
            end
            if (out_count == timing_idx) first_out_cycle = cycles;
            out_count++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout, run stopped after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b1;
        set_config(GAME_NONE, 16'h0000, 16'h0000);
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;

        // Idle after reset
        repeat (6) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("FAIL %0t out_valid expected 0 got %b", $time, out_valid);
                errors++;
            end
            if (in_ready !== 1'b1) begin
                $display("FAIL %0t in_ready expected 1 got %b", $time, in_ready);
                errors++;
            end
        end
        if (out_count != 0) begin
            $display("Output appeared with in_valid low");
            errors++;
        end
        end_test(1, "reset state");

        @(posedge clk);
        #2;
        set_config(GAME_NONE, 16'hFFFF, 16'h0000);  // Ignored, nothing banked
        timing_idx = out_count;
        run_reqs(40, 1'b0, 1'b0);
        drain();
        if (first_out_cycle != first_acc_cycle + OUT_AFTER) begin
            $display("First result took %0d edges after acceptance, expected %0d",
                     first_out_cycle - first_acc_cycle, OUT_AFTER);
            errors++;
        end
        end_test(2, "no banks");

        set_config(GAME_TWO_BANK, 16'hA5C3, 16'h3C81);
        run_reqs(100, 1'b0, 1'b0);
        drain();
        end_test(3, "two banks");

        set_config(GAME_FOUR_BANK, 16'h9E27, 16'h0F36);
        run_reqs(100, 1'b0, 1'b1);
        drain();
        end_test(4, "four banks");

        stall_seen = 1'b0;
        sent_total = 0;
        timing_idx = out_count;  // Reused as start mark
        run_reqs(150, 1'b1, 1'b0);
        drain();
        if (out_count - timing_idx != sent_total) begin
            $display("Sent %0d requests but %0d results came out",
                     sent_total, out_count - timing_idx);
            errors++;
        end
        if (!stall_seen) begin
            $display("in_ready never fell under back-pressure");
            errors++;
        end
        end_test(5, "back-pressure");

        set_config(GAME_FOUR_BANK, 16'h6B1D, 16'hC0A5);  // Pipeline empty here
        run_reqs(40, 1'b0, 1'b1);
        drain();
        end_test(6, "config change");

        $display("Summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
